/* include/bbc_mem_defs.svh */
`ifndef BBC_MEM_DEFS_SVH
`define BBC_MEM_DEFS_SVH

// ========================================
// memory bus geometry
// ========================================

// full bus address, bit 18 selects ram
`define BBC_ADDR_W 19
// byte wide data path
`define BBC_DATA_W 8
// offset inside one 16 KB bank
`define BBC_BANK_AW 14
// physical rom banks behind the slot map
`define BBC_ROM_BANKS 16
// 13 banks of 16 KB ram
`define BBC_RAM_DEPTH 212992

// ========================================
// joystick front end
// ========================================

// per-packet mouse movement limit
`define BBC_MDELTA_MAX 10
// fire button inside a joystick button word
`define BBC_JOY_FIRE_BIT 4
// pot value width seen by the adc model
`define BBC_POT_W 12

`endif

/* src/bbc_cfg_pkg.sv */
package bbc_cfg_pkg;

	// ========================================
	// machine configuration
	// ========================================

	// machine model, latched during reset
	typedef enum logic {
		model_b      = 1'b0,
		model_master = 1'b1
	} model_e;

	// filing system option from the menu
	// encodings 5..7 are unused
	typedef enum logic [2:0] {
		mmfs1     = 3'd0,
		mmfs2     = 3'd1,
		dfs       = 3'd2,
		mmfs1_dfs = 3'd3,
		mmfs2_dfs = 3'd4
	} fs_opt_e;

endpackage

/* src/bbc_bus_pkg.sv */
package bbc_bus_pkg;

	`include "bbc_mem_defs.svh"

	// logical 16 KB slot as the cpu sees it
	typedef logic [3:0] slot_t;
	// physical rom bank in the rom array
	typedef logic [3:0] bank_t;

	// normal view of the address
	typedef struct packed {
		logic                    ram_sel;
		slot_t                   slot;
		logic [`BBC_BANK_AW-1:0] offset;
	} mem_addr_log_t;

	// rom load view, bank is physical
	typedef struct packed {
		logic                    spare;
		bank_t                   bank;
		logic [`BBC_BANK_AW-1:0] offset;
	} mem_addr_load_t;

	// one bus address, two decodes
	typedef union packed {
		mem_addr_log_t  logical;
		mem_addr_load_t load;
	} mem_addr_u;

endpackage

/* src/mem_bus_if.sv */
interface mem_bus_if;

	// address from the wishbone side
	bbc_bus_pkg::mem_addr_u addr;
	// mapped physical bank
	bbc_bus_pkg::bank_t     bank;
	// slot holds a live rom
	logic                   rom_enable;
	// machine configuration
	bbc_cfg_pkg::model_e    model;
	bbc_cfg_pkg::fs_opt_e   fs_opt;

	// memory side, asks for a mapping
	modport requester (
		output addr,
		input  bank,
		input  rom_enable
	);

	// slot decoder side
	modport mapper (
		input  addr,
		input  model,
		input  fs_opt,
		output bank,
		output rom_enable
	);

endinterface

/* src/rom_slot_map.sv */
module rom_slot_map (
	mem_bus_if.mapper bus
);

	bbc_bus_pkg::slot_t slot;
	bbc_bus_pkg::bank_t bank;
	logic               enable;
	// filing system decode
	logic               mmfs1_sel;
	logic               mmfs_on;
	logic               dfs_on;

	assign slot = bus.addr.logical.slot;

	// v1 images sit in their own banks
	assign mmfs1_sel = (bus.fs_opt == bbc_cfg_pkg::mmfs1) ||
		(bus.fs_opt == bbc_cfg_pkg::mmfs1_dfs);
	assign mmfs_on = mmfs1_sel || (bus.fs_opt == bbc_cfg_pkg::mmfs2) ||
		(bus.fs_opt == bbc_cfg_pkg::mmfs2_dfs);
	assign dfs_on = (bus.fs_opt == bbc_cfg_pkg::dfs) ||
		(bus.fs_opt == bbc_cfg_pkg::mmfs1_dfs) ||
		(bus.fs_opt == bbc_cfg_pkg::mmfs2_dfs);

	// ========================================
	// slot to bank table
	// ========================================
	always_comb begin
		// unmapped slots read as zero
		bank   = '0;
		enable = 1'b0;
		if (bus.model == bbc_cfg_pkg::model_master) begin
			case (slot)
				// mmfs for the master
				4'd3: begin
					bank   = mmfs1_sel ? 4'd5 : 4'd15;
					enable = mmfs_on;
				end
				// mos, high rom
				4'd4: begin
					bank   = 4'd6;
					enable = 1'b1;
				end
				// dfs
				4'd9: begin
					bank   = 4'd7;
					enable = dfs_on;
				end
				// remaining paged roms, contiguous banks
				4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15: begin
					bank   = slot - 4'd2;
					enable = 1'b1;
				end
				default: ;
			endcase
		end else begin
			case (slot)
				// dfs
				4'd3: begin
					bank   = 4'd4;
					enable = dfs_on;
				end
				// os 1.2, high rom
				4'd4: begin
					bank   = 4'd0;
					enable = 1'b1;
				end
				// mmfs lives in slot 8 on the b
				4'd8: begin
					bank   = mmfs1_sel ? 4'd1 : 4'd14;
					enable = mmfs_on;
				end
				4'd14: begin
					bank   = 4'd2;
					enable = 1'b1;
				end
				// basic
				4'd15: begin
					bank   = 4'd3;
					enable = 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign bus.bank       = bank;
	assign bus.rom_enable = enable;

endmodule

/* src/paged_memory.sv */
`include "bbc_mem_defs.svh"

module paged_memory (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [`BBC_ADDR_W-1:0] wb_adr,
	input  logic [`BBC_DATA_W-1:0] wb_dat_w,
	input  logic                   rom_load,
	output logic [`BBC_DATA_W-1:0] wb_dat_r,
	output logic                   wb_ack,
	mem_bus_if.requester           bus
);

	// ram index is slot plus offset
	localparam int RAM_AW = `BBC_ADDR_W - 1;
	localparam int ROM_AW = $clog2(`BBC_ROM_BANKS) + `BBC_BANK_AW;
	localparam int ROM_DEPTH = `BBC_ROM_BANKS * (1 << `BBC_BANK_AW);

	// ========================================
	// storage
	// ========================================
	logic [`BBC_DATA_W-1:0] rom [ROM_DEPTH];
	logic [`BBC_DATA_W-1:0] ram [`BBC_RAM_DEPTH];

	logic                   ack_q;
	logic                   accept;
	logic [RAM_AW-1:0]      ram_idx;
	logic [ROM_AW-1:0]      rom_rd_idx;
	logic [ROM_AW-1:0]      rom_wr_idx;
	logic                   ram_wr;
	logic                   rom_wr;
	// read side, captured at accept
	logic [`BBC_DATA_W-1:0] ram_q;
	logic [`BBC_DATA_W-1:0] rom_q;
	logic                   ram_sel_q;
	logic                   rom_en_q;

	// mapper sees the raw address
	assign bus.addr = wb_adr;

	// new cycle only while ack is low
	assign accept = wb_cyc && wb_stb && !ack_q;

	assign ram_idx    = {bus.addr.logical.slot, bus.addr.logical.offset};
	assign rom_rd_idx = {bus.bank, bus.addr.logical.offset};
	// load path bypasses the slot map
	assign rom_wr_idx = {bus.addr.load.bank, bus.addr.load.offset};

	assign ram_wr = accept && wb_we && bus.addr.logical.ram_sel;
	// rom only writable while loading, rom half of the map
	assign rom_wr = accept && wb_we && rom_load && !bus.addr.load.spare;

	// ========================================
	// wishbone ack
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			// single cycle pulse
			ack_q <= accept;
		end
	end

	assign wb_ack = ack_q;

	// write port of each array
	always_ff @(posedge clk_sys) begin
		if (ram_wr) begin
			ram[ram_idx] <= wb_dat_w;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			rom[rom_wr_idx] <= wb_dat_w;
		end
	end

	// registered read, lands with ack
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			ram_q     <= ram[ram_idx];
			rom_q     <= rom[rom_rd_idx];
			ram_sel_q <= bus.addr.logical.ram_sel;
			rom_en_q  <= bus.rom_enable;
		end
	end

	// disabled or unmapped rom reads zero
	assign wb_dat_r = ram_sel_q ? ram_q : (rom_en_q ? rom_q : '0);

endmodule

/* src/mouse_axis_emu.sv */
`include "bbc_mem_defs.svh"

module mouse_axis_emu (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic [24:0]       mouse_packet,
	input  logic [15:0]       joy1_btn,
	input  logic              mouse_joy_off,
	output logic              emu_active,
	output logic signed [7:0] mouse_x,
	output logic signed [7:0] mouse_y,
	output logic              mouse_fire
);

	// ps2 packet fields
	localparam int STB_BIT = 24;
	localparam int X_SIGN  = 4;
	localparam int Y_SIGN  = 5;
	localparam int X_LSB   = 8;
	localparam int Y_LSB   = 16;
	localparam logic signed [8:0] DMAX = `BBC_MDELTA_MAX;

	logic [24:0]       pkt_q;
	logic              stb_prev;
	logic              toggle;
	logic              clear;
	logic signed [8:0] dx;
	logic signed [8:0] dy;
	logic signed [8:0] nx;
	logic signed [8:0] ny;

	// limit one packet's movement
	function automatic logic signed [8:0] clamp_delta(input logic signed [8:0] d);
		if (d > DMAX)
			return DMAX;
		if (d < -DMAX)
			return -DMAX;
		return d;
	endfunction

	// pin the position to the byte range
	function automatic logic signed [7:0] sat8(input logic signed [8:0] v);
		if (v > 9'sd127)
			return 8'sh7f;
		if (v < -9'sd128)
			return 8'sh80;
		return v[7:0];
	endfunction

	// 9 bit deltas, sign from the header byte
	assign dx = clamp_delta($signed({pkt_q[X_SIGN], pkt_q[X_LSB +: 8]}));
	assign dy = clamp_delta($signed({pkt_q[Y_SIGN], pkt_q[Y_LSB +: 8]}));
	// screen y grows downwards
	assign nx = mouse_x + dx;
	assign ny = mouse_y - dy;

	// new packet on either strobe edge
	assign toggle = pkt_q[STB_BIT] ^ stb_prev;
	// real joystick takes the port back
	assign clear = reset || (|joy1_btn) || mouse_joy_off;

	// ========================================
	// position accumulator
	// ========================================
	always_ff @(posedge clk_sys) begin
		pkt_q    <= mouse_packet;
		stb_prev <= pkt_q[STB_BIT];
		if (clear) begin
			emu_active <= 1'b0;
			mouse_x    <= '0;
			mouse_y    <= '0;
		end else if (toggle) begin
			emu_active <= 1'b1;
			mouse_x    <= sat8(nx);
			mouse_y    <= sat8(ny);
		end
	end

	// either button fires
	assign mouse_fire = |mouse_packet[1:0];

endmodule

/* src/joystick_port.sv */
`include "bbc_mem_defs.svh"

module joystick_port (
	input  logic                  emu_active,
	input  logic signed [7:0]     mouse_x,
	input  logic signed [7:0]     mouse_y,
	input  logic                  mouse_fire,
	input  logic [7:0]            joy1_x,
	input  logic [7:0]            joy1_y,
	input  logic [15:0]           joy1_btn,
	input  logic [7:0]            joy2_x,
	input  logic [7:0]            joy2_y,
	input  logic [15:0]           joy2_btn,
	input  logic                  swap_joy,
	output logic [`BBC_POT_W-1:0] pot1_x,
	output logic [`BBC_POT_W-1:0] pot1_y,
	output logic [`BBC_POT_W-1:0] pot2_x,
	output logic [`BBC_POT_W-1:0] pot2_y,
	output logic                  fire1_n,
	output logic                  fire2_n
);

	logic [7:0] a_x;
	logic [7:0] a_y;
	logic       a_fire;
	logic       b_fire;

	// signed axis to inverted pot reading
	function automatic logic [`BBC_POT_W-1:0] pot_conv(input logic [7:0] v);
		logic [7:0] t;
		t = 8'hff - {~v[7], v[6:0]};
		// widen by repeating the top nibble
		return {t, t[7:4]};
	endfunction

	// stick a, mouse overrides joystick 1
	assign a_x    = emu_active ? mouse_x : joy1_x;
	assign a_y    = emu_active ? mouse_y : joy1_y;
	assign a_fire = emu_active ? mouse_fire : joy1_btn[`BBC_JOY_FIRE_BIT];
	assign b_fire = joy2_btn[`BBC_JOY_FIRE_BIT];

	// port mux
	assign pot1_x  = swap_joy ? pot_conv(joy2_x) : pot_conv(a_x);
	assign pot1_y  = swap_joy ? pot_conv(joy2_y) : pot_conv(a_y);
	assign pot2_x  = swap_joy ? pot_conv(a_x) : pot_conv(joy2_x);
	assign pot2_y  = swap_joy ? pot_conv(a_y) : pot_conv(joy2_y);
	// fire lines are active low
	assign fire1_n = swap_joy ? ~b_fire : ~a_fire;
	assign fire2_n = swap_joy ? ~a_fire : ~b_fire;

endmodule

/* src/bbc_mem_top.sv */
`include "bbc_mem_defs.svh"

module bbc_mem_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	// wishbone classic slave
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [`BBC_ADDR_W-1:0] wb_adr,
	input  logic [`BBC_DATA_W-1:0] wb_dat_w,
	output logic [`BBC_DATA_W-1:0] wb_dat_r,
	output logic                   wb_ack,
	// configuration
	input  logic                   rom_load,
	input  bbc_cfg_pkg::model_e    model_sel,
	input  bbc_cfg_pkg::fs_opt_e   fs_opt,
	input  logic                   mouse_joy_off,
	input  logic                   swap_joy,
	// controllers
	input  logic [24:0]            mouse_packet,
	input  logic [15:0]            joy1_btn,
	input  logic [15:0]            joy2_btn,
	input  logic [7:0]             joy1_x,
	input  logic [7:0]             joy1_y,
	input  logic [7:0]             joy2_x,
	input  logic [7:0]             joy2_y,
	output logic [`BBC_POT_W-1:0]  pot1_x,
	output logic [`BBC_POT_W-1:0]  pot1_y,
	output logic [`BBC_POT_W-1:0]  pot2_x,
	output logic [`BBC_POT_W-1:0]  pot2_y,
	output logic                   fire1_n,
	output logic                   fire2_n
);

	bbc_cfg_pkg::model_e model_q;
	logic                emu_active;
	logic signed [7:0]   mouse_x;
	logic signed [7:0]   mouse_y;
	logic                mouse_fire;

	// model only changes across a reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model_sel;
	end

	// ========================================
	// memory system
	// ========================================
	mem_bus_if mem_bus ();

	assign mem_bus.model  = model_q;
	assign mem_bus.fs_opt = fs_opt;

	paged_memory u_mem (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.rom_load (rom_load),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.bus      (mem_bus.requester)
	);

	rom_slot_map u_map (
		.bus (mem_bus.mapper)
	);

	// ========================================
	// analog joysticks
	// ========================================
	mouse_axis_emu u_mouse (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mouse_packet  (mouse_packet),
		.joy1_btn      (joy1_btn),
		.mouse_joy_off (mouse_joy_off),
		.emu_active    (emu_active),
		.mouse_x       (mouse_x),
		.mouse_y       (mouse_y),
		.mouse_fire    (mouse_fire)
	);

	joystick_port u_joy (
		.emu_active (emu_active),
		.mouse_x    (mouse_x),
		.mouse_y    (mouse_y),
		.mouse_fire (mouse_fire),
		.joy1_x     (joy1_x),
		.joy1_y     (joy1_y),
		.joy1_btn   (joy1_btn),
		.joy2_x     (joy2_x),
		.joy2_y     (joy2_y),
		.joy2_btn   (joy2_btn),
		.swap_joy   (swap_joy),
		.pot1_x     (pot1_x),
		.pot1_y     (pot1_y),
		.pot2_x     (pot2_x),
		.pot2_y     (pot2_y),
		.fire1_n    (fire1_n),
		.fire2_n    (fire2_n)
	);

endmodule

/* verif/tb_bbc_mem_top.sv */
`include "bbc_mem_defs.svh"

module tb_bbc_mem_top;

	localparam int CLK_PERIOD = 4;
	localparam int ACK_LIMIT  = 8;
	localparam int N_RAM      = 24;
	localparam int N_MOUSE    = 90;
	localparam int N_JOY      = 32;
	// rom load, all slots per model and option, ram, ignored write, latch
	localparam int N_BUS      = 16 + 2 * 5 * 16 + 2 * N_RAM + 2 + 2 * 16;
	localparam int TIMEOUT    = (N_BUS * 4 + N_MOUSE * 4 + N_JOY * 2 + 400) * CLK_PERIOD;

	logic                   clk_sys;
	logic                   reset;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic                   wb_we;
	logic [`BBC_ADDR_W-1:0] wb_adr;
	logic [`BBC_DATA_W-1:0] wb_dat_w;
	logic [`BBC_DATA_W-1:0] wb_dat_r;
	logic                   wb_ack;
	logic                   rom_load;
	bbc_cfg_pkg::model_e    model_sel;
	bbc_cfg_pkg::fs_opt_e   fs_opt;
	logic                   mouse_joy_off;
	logic                   swap_joy;
	logic [24:0]            mouse_packet;
	logic [15:0]            joy1_btn;
	logic [15:0]            joy2_btn;
	logic [7:0]             joy1_x;
	logic [7:0]             joy1_y;
	logic [7:0]             joy2_x;
	logic [7:0]             joy2_y;
	logic [`BBC_POT_W-1:0]  pot1_x;
	logic [`BBC_POT_W-1:0]  pot1_y;
	logic [`BBC_POT_W-1:0]  pot2_x;
	logic [`BBC_POT_W-1:0]  pot2_y;
	logic                   fire1_n;
	logic                   fire2_n;

	// scoreboard state
	int                     mismatches;
	int                     protocol_errors;
	bbc_cfg_pkg::model_e    cur_model;
	logic [7:0]             rom_img [16];
	logic [`BBC_ADDR_W-1:0] ram_adr [N_RAM];
	logic [7:0]             ram_dat [N_RAM];
	// expected mouse position
	int                     mx;
	int                     my;
	logic                   stb_state;

	bbc_mem_top dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ========================================
	// reference model
	// ========================================

	// physical bank behind a logical slot
	function automatic logic [3:0] ref_bank(input bbc_cfg_pkg::model_e m,
		input bbc_cfg_pkg::fs_opt_e fs, input int s);
		logic       v1;
		logic [3:0] b;
		v1 = (fs == bbc_cfg_pkg::mmfs1) || (fs == bbc_cfg_pkg::mmfs1_dfs);
		b  = s - 2;
		if (m == bbc_cfg_pkg::model_b) begin
			case (s)
				3: return 4'd4;
				8: return v1 ? 4'd1 : 4'd14;
				14: return 4'd2;
				15: return 4'd3;
				default: return 4'd0;
			endcase
		end
		if (s == 3)
			return v1 ? 4'd5 : 4'd15;
		if (s == 4)
			return 4'd6;
		// master paged roms 9..15 run contiguous from bank 7
		if (s >= 9)
			return b;
		return 4'd0;
	endfunction

	// slot holds a rom that is switched on
	function automatic logic ref_enable(input bbc_cfg_pkg::model_e m,
		input bbc_cfg_pkg::fs_opt_e fs, input int s);
		logic has_dfs;
		logic has_mmfs;
		has_dfs  = (fs == bbc_cfg_pkg::dfs) || (fs == bbc_cfg_pkg::mmfs1_dfs) ||
			(fs == bbc_cfg_pkg::mmfs2_dfs);
		has_mmfs = (fs != bbc_cfg_pkg::dfs);
		if (m == bbc_cfg_pkg::model_b)
			return (s == 3) ? has_dfs : (s == 8) ? has_mmfs :
				(s == 4 || s == 14 || s == 15);
		return (s == 3) ? has_mmfs : (s == 9) ? has_dfs : (s == 4 || s >= 10);
	endfunction

	// stick byte to 12 bit inverted pot value
	function automatic logic [11:0] ref_pot(input logic [7:0] v);
		logic [7:0] t;
		t = 8'd255 - (v ^ 8'h80);
		return {t, t[7:4]};
	endfunction

	// one mouse packet applied to one axis
	function automatic int ref_mouse_step(input int pos, input int delta, input bit sub);
		int d;
		int p;
		d = (delta > `BBC_MDELTA_MAX) ? `BBC_MDELTA_MAX :
			(delta < -`BBC_MDELTA_MAX) ? -`BBC_MDELTA_MAX : delta;
		p = sub ? pos - d : pos + d;
		if (p > 127)
			p = 127;
		if (p < -128)
			p = -128;
		return p;
	endfunction

	// ========================================
	// checks and bus tasks
	// ========================================
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			mismatches++;
		end
	endtask

	// one wishbone classic cycle from falling edge to falling edge
	task automatic bus_xfer(input logic we, input logic [`BBC_ADDR_W-1:0] adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		int cycles;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		cycles   = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
		end while (!wb_ack && cycles < ACK_LIMIT);
		if (!wb_ack) begin
			$display("no wb_ack within %0d cycles at address %0h", ACK_LIMIT, adr);
			protocol_errors++;
		end else if (cycles != 1) begin
			$display("wb_ack came %0d cycles after the request at address %0h", cycles, adr);
			protocol_errors++;
		end
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		// idle cycle so the next request starts with ack low
		@(negedge clk_sys);
	endtask

	task automatic apply_reset(input bbc_cfg_pkg::model_e m);
		@(negedge clk_sys);
		reset     = 1'b1;
		model_sel = m;
		repeat (4) @(negedge clk_sys);
		reset     = 1'b0;
		cur_model = m;
		mx        = 0;
		my        = 0;
	endtask

	// offset 0 of every rom slot under the current option
	task automatic check_slots(input string tag);
		logic [7:0] rd;
		logic [7:0] exp;
		for (int s = 0; s < 16; s++) begin
			bus_xfer(1'b0, {1'b0, s[3:0], 14'h0}, 8'h00, rd);
			exp = ref_enable(cur_model, fs_opt, s) ?
				rom_img[ref_bank(cur_model, fs_opt, s)] : 8'h00;
			check_value($sformatf("%s model %0d fs %0d slot %0d", tag, cur_model, fs_opt, s),
				exp, rd);
		end
	endtask

	// strobe toggle with new deltas
	// position lands two edges later
	task automatic mouse_step(input int dx, input int dy, input logic [1:0] btn);
		logic [8:0] ex;
		logic [8:0] ey;
		ex           = dx[8:0];
		ey           = dy[8:0];
		stb_state    = ~stb_state;
		mouse_packet = {stb_state, ey[7:0], ex[7:0], 2'b00, ey[8], ex[8], 2'b00, btn};
		mx           = ref_mouse_step(mx, dx, 1'b0);
		my           = ref_mouse_step(my, dy, 1'b1);
		repeat (2) @(negedge clk_sys);
		check_value("mouse pot1_x", ref_pot(mx[7:0]), pot1_x);
		check_value("mouse pot1_y", ref_pot(my[7:0]), pot1_y);
		check_value("mouse fire1_n", !(|btn), fire1_n);
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		logic [7:0]  rd;
		logic [7:0]  a_x;
		logic [7:0]  a_y;
		logic        a_fire;
		logic        b_fire;
		int          dx;
		int          dy;
		void'($urandom(28));
		clk_sys       = 1'b0;
		reset         = 1'b1;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_w      = '0;
		rom_load      = 1'b0;
		model_sel     = bbc_cfg_pkg::model_b;
		fs_opt        = bbc_cfg_pkg::dfs;
		mouse_joy_off = 1'b0;
		swap_joy      = 1'b0;
		mouse_packet  = '0;
		stb_state     = 1'b0;
		joy1_btn      = '0;
		joy2_btn      = '0;
		joy1_x        = 8'h00;
		joy1_y        = 8'h00;
		joy2_x        = 8'h00;
		joy2_y        = 8'h00;
		mismatches    = 0;
		protocol_errors = 0;
		apply_reset(bbc_cfg_pkg::model_b);

		// distinct nonzero marker per bank with the bank in the low nibble
		rom_load = 1'b1;
		for (int b = 0; b < 16; b++) begin
			rom_img[b] = {4'($urandom_range(15, 1)), b[3:0]};
			bus_xfer(1'b1, {1'b0, b[3:0], 14'h0}, rom_img[b], rd);
		end
		rom_load = 1'b0;

		// mapping and filing system gating for both models and every option
		for (int m = 0; m < 2; m++) begin
			apply_reset(bbc_cfg_pkg::model_e'(m));
			for (int f = 0; f < 5; f++) begin
				fs_opt = bbc_cfg_pkg::fs_opt_e'(f);
				check_slots("rom map");
			end
		end

		// ram offsets kept distinct through the index bits
		for (int i = 0; i < N_RAM; i++) begin
			ram_adr[i] = {1'b1, 4'($urandom_range(12)), i[4:0], 9'($urandom)};
			ram_dat[i] = 8'($urandom);
			bus_xfer(1'b1, ram_adr[i], ram_dat[i], rd);
		end
		for (int i = 0; i < N_RAM; i++) begin
			bus_xfer(1'b0, ram_adr[i], 8'h00, rd);
			check_value($sformatf("ram %0h", ram_adr[i]), ram_dat[i], rd);
		end

		// rom write without rom_load is dropped
		// master slot 15 is bank 13
		bus_xfer(1'b1, {1'b0, 4'd15, 14'h0}, ~rom_img[13], rd);
		bus_xfer(1'b0, {1'b0, 4'd15, 14'h0}, 8'h00, rd);
		check_value("rom write ignored", rom_img[13], rd);

		// model only moves across a reset
		model_sel = bbc_cfg_pkg::model_b;
		check_slots("latch hold");
		apply_reset(bbc_cfg_pkg::model_b);
		check_slots("latch new");

		// mixed mouse deltas then runs into both saturation corners
		joy1_x = 8'h5a;
		joy1_y = 8'ha5;
		for (int i = 0; i < N_MOUSE; i++) begin
			if (i < 20) begin
				dx = int'($urandom_range(60)) - 30;
				dy = int'($urandom_range(60)) - 30;
			end else if (i < 55) begin
				dx = int'($urandom_range(40, 8));
				dy = -int'($urandom_range(40, 8));
			end else begin
				dx = -int'($urandom_range(40, 8));
				dy = int'($urandom_range(40, 8));
			end
			mouse_step(dx, dy, 2'($urandom));
		end
		// joystick button hands port 1 back to the stick
		joy1_btn = 16'h0001;
		@(negedge clk_sys);
		check_value("release pot1_x", ref_pot(joy1_x), pot1_x);
		check_value("release pot1_y", ref_pot(joy1_y), pot1_y);
		check_value("release fire1_n", 1'b1, fire1_n);

		// plain joysticks with swap alternating
		for (int i = 0; i < N_JOY; i++) begin
			swap_joy = i[0];
			joy1_x   = 8'($urandom);
			joy1_y   = 8'($urandom);
			joy2_x   = 8'($urandom);
			joy2_y   = 8'($urandom);
			joy1_btn = 16'($urandom);
			joy2_btn = 16'($urandom);
			@(negedge clk_sys);
			a_x    = swap_joy ? joy2_x : joy1_x;
			a_y    = swap_joy ? joy2_y : joy1_y;
			a_fire = swap_joy ? joy2_btn[`BBC_JOY_FIRE_BIT] : joy1_btn[`BBC_JOY_FIRE_BIT];
			b_fire = swap_joy ? joy1_btn[`BBC_JOY_FIRE_BIT] : joy2_btn[`BBC_JOY_FIRE_BIT];
			check_value("joy pot1_x", ref_pot(a_x), pot1_x);
			check_value("joy pot1_y", ref_pot(a_y), pot1_y);
			check_value("joy pot2_x", ref_pot(swap_joy ? joy1_x : joy2_x), pot2_x);
			check_value("joy pot2_y", ref_pot(swap_joy ? joy1_y : joy2_y), pot2_y);
			check_value("joy fire1_n", !a_fire, fire1_n);
			check_value("joy fire2_n", !b_fire, fire2_n);
		end

		$display("mismatches %0d, protocol errors %0d", mismatches, protocol_errors);
		if (mismatches == 0 && protocol_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog sized from the bus operations and mouse steps
	initial begin
		#(TIMEOUT);
		$display("watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

endmodule

/* bbc_mem_sys.f */
+incdir+include
src/bbc_cfg_pkg.sv
src/bbc_bus_pkg.sv
src/mem_bus_if.sv
src/rom_slot_map.sv
src/paged_memory.sv
src/mouse_axis_emu.sv
src/joystick_port.sv
src/bbc_mem_top.sv
verif/tb_bbc_mem_top.sv

/* Bender.yml */
package:
  name: bbc_mem_sys

sources:
  - include_dirs:
      - include
    files:
      - src/bbc_cfg_pkg.sv
      - src/bbc_bus_pkg.sv
      - src/mem_bus_if.sv
      - src/rom_slot_map.sv
      - src/paged_memory.sv
      - src/mouse_axis_emu.sv
      - src/joystick_port.sv
      - src/bbc_mem_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_bbc_mem_top.sv
